//--- include/adc_slice_params.svh
// tap count, code width, accumulation window and pipeline latency macros
`ifndef ADC_SLICE_PARAMS_SVH
`define ADC_SLICE_PARAMS_SVH

// number of delay-chain taps in one TDC snapshot
`define ADC_NTAPS 255

// width of the magnitude code produced by the ones counter
`define ADC_NADC 8

// number of samples summed into one accumulator window
`define ADC_ACC_WINDOW 16

// accumulator word width, wide enough for the signed window sum
`define ADC_ACC_WIDTH 20

// cycles from the input strobe to the sample strobe
// one cycle in capture and two in the adder
`define ADC_LATENCY 3

`endif

//--- hdl/adc_slice_pkg.sv
// tap, code, sample and accumulator types for the stochastic ADC slice
`include "adc_slice_params.svh"

package adc_slice_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // plain vector types
    ////////////////////////////////////////////////////////////////////////////

    // raw or corrected delay-chain snapshot, one bit per tap
    typedef logic [`ADC_NTAPS-1:0] tap_vec_t;

    // binary tap-length control
    typedef logic [`ADC_NADC-1:0] tap_len_t;

    // magnitude of one conversion
    typedef logic [`ADC_NADC-1:0] adc_code_t;

    // signed running sum over one window
    typedef logic signed [`ADC_ACC_WIDTH-1:0] acc_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // grouped payloads
    ////////////////////////////////////////////////////////////////////////////

    // arbiter sign together with the delay-chain flip-flops
    typedef struct packed {
        logic     sign;
        tap_vec_t taps;
    } tdc_snap_t;

    // sign-magnitude result of one conversion
    typedef struct packed {
        logic      sign;
        adc_code_t code;
    } adc_sample_t;

endpackage

//--- hdl/bin2thm.sv
// binary to thermometer decoder for the tap-length control
`timescale 1ns/1ps
`include "adc_slice_params.svh"

module bin2thm
    import adc_slice_pkg::*;
#(
    parameter int WIDTH = `ADC_NADC,
    parameter int NOUT  = `ADC_NTAPS
) (
    input  tap_len_t bin,
    output tap_vec_t thm
);

    // output bit i is set for every tap below the requested length
    // so a length of zero masks the whole chain
    genvar i;
    generate
        for (i = 0; i < NOUT; i++) begin : g_thm
            assign thm[i] = (bin > WIDTH'(i));
        end
    endgenerate

endmodule

//--- hdl/tdc_capture.sv
// phase-reverse synchronizer, tap masking, odd-tap correction and capture register
`timescale 1ns/1ps

module tdc_capture
    import adc_slice_pkg::*;
(
    input  logic      clk_adder,
    input  logic      rstb,
    input  logic      snap_valid,
    input  tdc_snap_t snap,
    input  tap_vec_t  tap_mask,
    input  logic      en_phase_reverse,
    output logic      cap_valid,
    output tdc_snap_t cap_snap
);

    logic     pr_meta;
    logic     pr_sync;
    tap_vec_t taps_fixed;
    tap_vec_t taps_masked;

    ////////////////////////////////////////////////////////////////////////////
    // phase-reverse synchronizer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            pr_meta <= 1'b0;
            pr_sync <= 1'b0;
        end else begin
            pr_meta <= en_phase_reverse;
            pr_sync <= pr_meta;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tap correction and capture
    ////////////////////////////////////////////////////////////////////////////

    // odd taps were sampled on the opposite clock phase when reversal is on
    always_comb begin
        for (int i = 0; i < $bits(tap_vec_t); i++) begin
            taps_fixed[i] = snap.taps[i] ^ (pr_sync & i[0]);
        end
    end

    // taps beyond the programmed length are forced to zero
    assign taps_masked = taps_fixed & tap_mask;

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= snap_valid;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (snap_valid) begin
            cap_snap.sign <= snap.sign;
            cap_snap.taps <= taps_masked;
        end
    end

endmodule

//--- hdl/wallace_adder.sv
// two-stage pipelined ones-counting tree producing the sign-magnitude code
`timescale 1ns/1ps
`include "adc_slice_params.svh"

module wallace_adder
    import adc_slice_pkg::*;
(
    input  logic        clk_adder,
    input  logic        rstb,
    input  logic        cap_valid,
    input  tdc_snap_t   cap_snap,
    output logic        sample_valid,
    output adc_sample_t sample
);

    localparam int GRP_SIZE = 15;
    localparam int NGRP     = `ADC_NTAPS / GRP_SIZE;

    logic [NGRP-1:0][3:0] grp_cnt;
    logic                 sign_s1;
    logic                 valid_s1;
    adc_code_t            code_sum;

    // full adder cell returning carry then sum
    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        return {(a & b) | (c & (a ^ b)), a ^ b ^ c};
    endfunction

    // counts the ones of a 15-bit group with rows of full adders
    // each row compresses one weight column and passes carries up
    function automatic logic [3:0] count15(input logic [14:0] b);
        logic [4:0] s_a;
        logic [4:0] c_a;
        logic [1:0] r_b0;
        logic [1:0] r_b1;
        logic [1:0] r_t0;
        logic [1:0] r_t1;
        logic [1:0] r_t2;
        logic [1:0] r_v;
        for (int k = 0; k < 5; k++) begin
            {c_a[k], s_a[k]} = fa(b[3*k], b[3*k+1], b[3*k+2]);
        end
        // weight one column
        r_b0 = fa(s_a[0], s_a[1], s_a[2]);
        r_b1 = fa(s_a[3], s_a[4], r_b0[0]);
        // weight two column
        r_t0 = fa(c_a[0], c_a[1], c_a[2]);
        r_t1 = fa(c_a[3], c_a[4], r_b0[1]);
        r_t2 = fa(r_t0[0], r_t1[0], r_b1[1]);
        // the carry of the weight four column is the top bit
        r_v  = fa(r_t0[1], r_t1[1], r_t2[1]);
        return {r_v[1], r_v[0], r_t2[0], r_b1[0]};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage one counts the groups
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adder) begin
        for (int g = 0; g < NGRP; g++) begin
            grp_cnt[g] <= count15(cap_snap.taps[g*GRP_SIZE +: GRP_SIZE]);
        end
        sign_s1 <= cap_snap.sign;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage two forms the final sum
    ////////////////////////////////////////////////////////////////////////////

    // the largest total is 255 so the code never overflows
    always_comb begin
        code_sum = '0;
        for (int g = 0; g < NGRP; g++) begin
            code_sum = code_sum + adc_code_t'(grp_cnt[g]);
        end
    end

    always_ff @(posedge clk_adder) begin
        sample.sign <= sign_s1;
        sample.code <= code_sum;
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            valid_s1     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            valid_s1     <= cap_valid;
            sample_valid <= valid_s1;
        end
    end

endmodule

//--- hdl/sample_accumulator.sv
// windowed accumulator of signed sample codes with a total strobe
`timescale 1ns/1ps
`include "adc_slice_params.svh"

module sample_accumulator
    import adc_slice_pkg::*;
(
    input  logic        clk_adder,
    input  logic        rstb,
    input  logic        sample_valid,
    input  adc_sample_t sample,
    output logic        acc_valid,
    output acc_word_t   acc_out
);

    localparam int CNT_W = $clog2(`ADC_ACC_WINDOW);

    logic [CNT_W-1:0] sample_cnt;
    acc_word_t        acc_sum;
    acc_word_t        code_mag;
    acc_word_t        acc_next;

    // a sign of one adds the code and a sign of zero subtracts it
    assign code_mag = {{(`ADC_ACC_WIDTH - `ADC_NADC){1'b0}}, sample.code};
    assign acc_next = sample.sign ? (acc_sum + code_mag) : (acc_sum - code_mag);

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            sample_cnt <= '0;
            acc_sum    <= '0;
            acc_out    <= '0;
            acc_valid  <= 1'b0;
        end else begin
            acc_valid <= 1'b0;
            if (sample_valid) begin
                if (sample_cnt == CNT_W'(`ADC_ACC_WINDOW - 1)) begin
                    // the last sample of the window publishes the total and restarts the sum
                    acc_out    <= acc_next;
                    acc_valid  <= 1'b1;
                    acc_sum    <= '0;
                    sample_cnt <= '0;
                end else begin
                    acc_sum    <= acc_next;
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/stochastic_adc_backend.sv
// top level of the ADC slice back end with decoder, capture, adder and accumulator
`timescale 1ns/1ps

module stochastic_adc_backend
    import adc_slice_pkg::*;
(
    input  logic        clk_adder,
    input  logic        rstb,
    input  logic        snap_valid,
    input  tdc_snap_t   snap,
    input  tap_len_t    tap_len,
    input  logic        en_phase_reverse,
    output logic        sample_valid,
    output adc_sample_t sample,
    output logic        acc_valid,
    output acc_word_t   acc_out
);

    tap_vec_t  tap_mask;
    logic      cap_valid;
    tdc_snap_t cap_snap;

    bin2thm i_b2t_taps (
        .bin (tap_len),
        .thm (tap_mask)
    );

    tdc_capture i_capture (
        .clk_adder        (clk_adder),
        .rstb             (rstb),
        .snap_valid       (snap_valid),
        .snap             (snap),
        .tap_mask         (tap_mask),
        .en_phase_reverse (en_phase_reverse),
        .cap_valid        (cap_valid),
        .cap_snap         (cap_snap)
    );

    wallace_adder i_adder (
        .clk_adder    (clk_adder),
        .rstb         (rstb),
        .cap_valid    (cap_valid),
        .cap_snap     (cap_snap),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    sample_accumulator i_accum (
        .clk_adder    (clk_adder),
        .rstb         (rstb),
        .sample_valid (sample_valid),
        .sample       (sample),
        .acc_valid    (acc_valid),
        .acc_out      (acc_out)
    );

endmodule

//--- verif/stochastic_adc_asserts.sv
// concurrent checks on the strobes and reset behavior of the ADC back end
`timescale 1ns/1ps
`include "adc_slice_params.svh"

module stochastic_adc_asserts (
    input logic clk_adder,
    input logic rstb,
    input logic snap_valid,
    input logic sample_valid,
    input logic acc_valid
);

    // both valid outputs stay low while reset is held
    a_reset_quiet: assert property (@(posedge clk_adder)
        !rstb |-> (!sample_valid && !acc_valid))
        else $error("valid output high during reset");

    // the sample strobe trails the input strobe by the pipeline latency
    a_latency: assert property (@(posedge clk_adder) disable iff (!rstb)
        sample_valid == $past(snap_valid, `ADC_LATENCY))
        else $error("sample_valid does not follow snap_valid by the pipeline latency");

    a_acc_single: assert property (@(posedge clk_adder) disable iff (!rstb)
        acc_valid |=> !acc_valid)
        else $error("acc_valid high on two consecutive cycles");

endmodule

bind stochastic_adc_backend stochastic_adc_asserts u_asserts (
    .clk_adder    (clk_adder),
    .rstb         (rstb),
    .snap_valid   (snap_valid),
    .sample_valid (sample_valid),
    .acc_valid    (acc_valid)
);

//--- verif/tb_stochastic_adc.sv
// testbench for the ADC back end with LFSR stimulus, reference model, checker and watchdog
`timescale 1ns/1ps
`include "adc_slice_params.svh"

module tb_stochastic_adc
    import adc_slice_pkg::*;
();

    localparam int RST_CYCLES = 16;
    localparam int IDLE_GAP   = 3;
    localparam int MAX_GAP    = 3;
    localparam int N_BURST    = 16;
    localparam int N_SAMPLES  = 2*N_BURST + 5*N_BURST + 2*N_BURST + 24 + 5 + N_BURST;
    // one window closes after the mid-run reset and all the others before it
    localparam int N_WINDOWS  = (N_SAMPLES - N_BURST) / `ADC_ACC_WINDOW + 1;
    localparam int WATCHDOG_CYCLES = 2*RST_CYCLES + N_SAMPLES*(MAX_GAP + 1)
                                     + 12*IDLE_GAP + `ADC_LATENCY + 32;

    logic        clk_adder = 1'b0;
    logic        rstb;
    logic        snap_valid;
    tdc_snap_t   snap;
    tap_len_t    tap_len;
    logic        en_phase_reverse;
    logic        sample_valid;
    adc_sample_t sample;
    logic        acc_valid;
    acc_word_t   acc_out;

    logic [31:0] lfsr = 32'ha456_aaab;
    bit          pr_model = 1'b0;
    int          cycle = 0;
    int          win_sum = 0;
    int          win_cnt = 0;
    int          n_windows = 0;
    adc_sample_t exp_q[$];
    int          due_q[$];
    acc_word_t   acc_exp_q[$];
    int          acc_due_q[$];
    tap_len_t    mask_lens[5] = '{8'd0, 8'd1, 8'd128, 8'd255, 8'd37};

    stochastic_adc_backend UUT (.*);

    always #2 clk_adder = ~clk_adder;

    always @(posedge clk_adder) cycle <= cycle + 1;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("ERR %s got %h expected %h", name, got, want);
        $display("** FAIL **");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "check failed");
    endtask

    // Fibonacci register for x^32 + x^22 + x^2 + x + 1 that hands out each new bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // ones count of the corrected and masked taps
    function automatic adc_code_t expected_code(input tap_vec_t taps, input tap_len_t len,
                                                input bit pr);
        int   ones;
        logic b;
        ones = 0;
        for (int i = 0; i < `ADC_NTAPS; i++) begin
            b = (pr && (i % 2 == 1)) ? ~taps[i] : taps[i];
            if (i < int'(len) && b) ones++;
        end
        return adc_code_t'(ones);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks are entered and left on a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_sample(input int gap);
        tdc_snap_t   s;
        adc_sample_t e;
        logic [31:0] r;
        for (int i = 0; i < `ADC_NTAPS; i++) begin
            take_bits(1, r);
            s.taps[i] = r[0];
        end
        take_bits(1, r);
        s.sign = r[0];
        e.sign = s.sign;
        e.code = expected_code(s.taps, tap_len, pr_model);
        exp_q.push_back(e);
        due_q.push_back(cycle + `ADC_LATENCY);
        snap = s;
        snap_valid = 1'b1;
        @(negedge clk_adder);
        snap_valid = 1'b0;
        repeat (gap) @(negedge clk_adder);
    endtask

    task automatic send_burst(input int n, input bit back_to_back);
        logic [31:0] g;
        for (int k = 0; k < n; k++) begin
            g = '0;
            if (!back_to_back) take_bits(2, g);
            send_sample(int'(g[1:0]));
        end
    endtask

    task automatic set_tap_len(input tap_len_t len);
        tap_len = len;
        repeat (IDLE_GAP) @(negedge clk_adder);
    endtask

    task automatic set_phase_reverse(input bit on);
        en_phase_reverse = on;
        pr_model = on;
        repeat (IDLE_GAP) @(negedge clk_adder);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // the checker samples the outputs on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_adder) begin : compare
        adc_sample_t e;
        int          due;
        if (!rstb) begin
            assert (!sample_valid) else report_mismatch("sample_valid", sample_valid, 0);
            assert (!acc_valid) else report_mismatch("acc_valid", acc_valid, 0);
            assert (acc_out == '0) else report_mismatch("acc_out", acc_out, 0);
            exp_q.delete();
            due_q.delete();
            acc_exp_q.delete();
            acc_due_q.delete();
            win_sum = 0;
            win_cnt = 0;
        end else begin
            if (sample_valid) begin
                assert (exp_q.size() > 0)
                    else report_failure("sample_valid with no strobe pending");
                e = exp_q.pop_front();
                due = due_q.pop_front();
                assert (cycle == due) else report_mismatch("sample_valid cycle", cycle, due);
                assert (sample.code == e.code)
                    else report_mismatch("sample.code", sample.code, e.code);
                assert (sample.sign == e.sign)
                    else report_mismatch("sample.sign", sample.sign, e.sign);
                win_sum = e.sign ? win_sum + int'(e.code) : win_sum - int'(e.code);
                win_cnt++;
                if (win_cnt == `ADC_ACC_WINDOW) begin
                    acc_exp_q.push_back(acc_word_t'(win_sum));
                    acc_due_q.push_back(cycle + 1);
                    win_sum = 0;
                    win_cnt = 0;
                end
            end else begin
                assert (due_q.size() == 0 || due_q[0] >= cycle)
                    else report_failure("a sample did not appear three cycles after its strobe");
            end
            if (acc_valid) begin
                assert (acc_exp_q.size() > 0)
                    else report_failure("acc_valid pulsed with no full window");
                due = acc_due_q.pop_front();
                assert (cycle == due) else report_mismatch("acc_valid cycle", cycle, due);
                assert (acc_out == acc_exp_q[0])
                    else report_mismatch("acc_out", acc_out, acc_exp_q[0]);
                void'(acc_exp_q.pop_front());
                n_windows++;
            end else begin
                assert (acc_due_q.size() == 0 || acc_due_q[0] > cycle)
                    else report_failure("acc_valid missing after the last sample of a window");
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        report_failure("outputs stopped arriving before the test sequence finished");
    end

    initial begin
        rstb = 1'b0;
        snap_valid = 1'b0;
        snap = '0;
        tap_len = 8'd255;
        en_phase_reverse = 1'b0;
        repeat (RST_CYCLES) @(negedge clk_adder);
        rstb = 1'b1;
        repeat (IDLE_GAP) @(negedge clk_adder);
        send_burst(2*N_BURST, 1'b0);
        foreach (mask_lens[k]) begin
            set_tap_len(mask_lens[k]);
            send_burst(N_BURST, 1'b0);
        end
        set_phase_reverse(1'b1);
        set_tap_len(8'd200);
        send_burst(N_BURST, 1'b0);
        set_tap_len(8'd255);
        send_burst(N_BURST, 1'b0);
        set_phase_reverse(1'b0);
        send_burst(24, 1'b1);
        // reset lands between edges with a partial window and samples in flight
        send_burst(5, 1'b1);
        #1 rstb = 1'b0;
        repeat (6) @(negedge clk_adder);
        rstb = 1'b1;
        repeat (IDLE_GAP) @(negedge clk_adder);
        send_burst(N_BURST, 1'b0);
        while (exp_q.size() != 0 || acc_exp_q.size() != 0) @(negedge clk_adder);
        repeat (4) @(negedge clk_adder);
        if (n_windows == N_WINDOWS) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("windows counted %0d, expected %0d", n_windows, N_WINDOWS);
            $display("** FAIL **");
            $fatal(1, "wrong number of windows");
        end
    end

endmodule

//--- stochastic_adc_backend.f
+incdir+include
hdl/adc_slice_pkg.sv
hdl/bin2thm.sv
hdl/tdc_capture.sv
hdl/wallace_adder.sv
hdl/sample_accumulator.sv
hdl/stochastic_adc_backend.sv
verif/stochastic_adc_asserts.sv
verif/tb_stochastic_adc.sv

//--- Makefile
# Verilator build and run for the stochastic ADC back end

VERILATOR ?= verilator
TOP       ?= tb_stochastic_adc
DUT_TOP   ?= stochastic_adc_backend
FILELIST  ?= stochastic_adc_backend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SOURCES := $(wildcard hdl/*.sv) $(wildcard verif/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
